// ==== list.f ====
+incdir+include
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/functTable.sv
logic/opcodeTable.sv
logic/trapControl.sv
logic/controlUnit.sv
test/controlUnitTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the control unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

rm -f sim.log build.log
verilator --binary --timing --assert -f list.f --top-module controlUnitTb \
    --Mdir obj_dir -o controlUnitSim > build.log 2>&1 \
    && ./obj_dir/controlUnitSim > sim.log 2>&1 \
    || { cat build.log; echo "FAIL: see errors above" >> sim.log; }

cat sim.log
if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
exit 0

// ==== include/ctrlRefModel.svh ====
`ifndef CTRL_REF_MODEL_SVH
`define CTRL_REF_MODEL_SVH

// expected control bundle, written straight from the decode rules
function automatic ctrlPkg::ctrlSignals expectCtrl(
    isaPkg::instrWord instr,
    logic             irq,
    logic             pc31
);
    ctrlPkg::ctrlSignals exp;
    logic [5:0]          op;
    logic [5:0]          fn;
    logic                known;
    exp   = ctrlPkg::ctrlNop;
    op    = instr.r.opcode;
    fn    = instr.r.funct;
    known = 1'b1;

    if (op == isaPkg::opSpecial) begin
        exp.regWr   = 1'b1;
        exp.sign    = fn inside {isaPkg::fnAdd, isaPkg::fnSub, isaPkg::fnSlt};
        exp.aluSrc1 = fn inside {isaPkg::fnSll, isaPkg::fnSrl, isaPkg::fnSra};
        case (fn)
            isaPkg::fnAdd, isaPkg::fnAddu: exp.aluFun = ctrlPkg::aluAdd;
            isaPkg::fnSub, isaPkg::fnSubu: exp.aluFun = ctrlPkg::aluSub;
            isaPkg::fnAnd: exp.aluFun = ctrlPkg::aluAnd;
            isaPkg::fnOr:  exp.aluFun = ctrlPkg::aluOr;
            isaPkg::fnXor: exp.aluFun = ctrlPkg::aluXor;
            isaPkg::fnNor: exp.aluFun = ctrlPkg::aluNor;
            isaPkg::fnSll: exp.aluFun = ctrlPkg::aluSll;
            isaPkg::fnSrl: exp.aluFun = ctrlPkg::aluSrl;
            isaPkg::fnSra: exp.aluFun = ctrlPkg::aluSra;
            isaPkg::fnSlt: exp.aluFun = ctrlPkg::aluLt;
            isaPkg::fnJr: begin
                exp.regWr = 1'b0;
                exp.pcSrc = ctrlPkg::pcReg;
            end
            isaPkg::fnJalr: begin
                exp.pcSrc    = ctrlPkg::pcReg;
                exp.memToReg = ctrlPkg::wbLink;
            end
            default: known = 1'b0;
        endcase
    end else begin
        exp.aluSrc2 = op inside {isaPkg::opLw, isaPkg::opSw, isaPkg::opLui, isaPkg::opAddi,
                                 isaPkg::opAddiu, isaPkg::opAndi, isaPkg::opSlti,
                                 isaPkg::opSltiu};
        exp.extOp   = exp.aluSrc2 && (op != isaPkg::opAndi);
        exp.regWr   = exp.aluSrc2 && (op != isaPkg::opSw);
        exp.regDst  = exp.regWr ? ctrlPkg::dstRt : ctrlPkg::dstRd;
        exp.sign    = op inside {isaPkg::opAddi, isaPkg::opSlti};
        exp.luOp    = (op == isaPkg::opLui);
        exp.memRd   = (op == isaPkg::opLw);
        exp.memWr   = (op == isaPkg::opSw);
        if (op == isaPkg::opLw) exp.memToReg = ctrlPkg::wbMem;
        if (op == isaPkg::opAndi) exp.aluFun = ctrlPkg::aluAnd;
        if (op inside {isaPkg::opSlti, isaPkg::opSltiu}) exp.aluFun = ctrlPkg::aluLt;
        if (op inside {isaPkg::opBeq, isaPkg::opBne, isaPkg::opBlez, isaPkg::opBgtz,
                       isaPkg::opBltz}) begin
            exp.pcSrc = ctrlPkg::pcBranch;
            exp.extOp = 1'b1;
        end
        case (op)
            isaPkg::opBeq:  exp.aluFun = ctrlPkg::aluEq;
            isaPkg::opBne:  exp.aluFun = ctrlPkg::aluNeq;
            isaPkg::opBlez: exp.aluFun = ctrlPkg::aluLez;
            isaPkg::opBgtz: exp.aluFun = ctrlPkg::aluGtz;
            isaPkg::opBltz: exp.aluFun = ctrlPkg::aluLtz;
            isaPkg::opJ:    exp.pcSrc = ctrlPkg::pcJump;
            isaPkg::opJal: begin
                exp.pcSrc    = ctrlPkg::pcJump;
                exp.regWr    = 1'b1;
                exp.regDst   = ctrlPkg::dstRa;
                exp.memToReg = ctrlPkg::wbLink;
            end
            default: known = exp.aluSrc2;
        endcase
    end

    if (!known) exp = ctrlPkg::ctrlNop;
    if (!pc31 && (irq || !known)) begin
        exp          = ctrlPkg::ctrlNop;
        exp.regWr    = 1'b1;
        exp.regDst   = ctrlPkg::dstXp;
        exp.memToReg = ctrlPkg::wbLink;
        exp.pcSrc    = irq ? ctrlPkg::pcIrq : ctrlPkg::pcExcept;
    end
    return exp;
endfunction

`endif

// ==== test/controlUnitTb.sv ====
module controlUnitTb;
    import isaPkg::*;
    import ctrlPkg::*;

    `include "ctrlRefModel.svh"

    localparam int numRtype   = 14;
    localparam int numItype   = 15;
    localparam int numIllegal = 3;
    localparam int numSample  = 4;
    localparam int numRandom  = 300;
    localparam int totalVecs  = numRtype + numItype + numIllegal + 2 * numSample + numRandom;
    localparam int numFields  = 12;

    localparam logic [5:0] functList [numRtype] = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr,
        fnXor, fnNor, fnSll, fnSrl, fnSra, fnSlt, fnJr, fnJalr};
    localparam logic [5:0] opList [numItype] = '{opLw, opSw, opLui, opAddi, opAddiu, opAndi,
        opSlti, opSltiu, opBeq, opBne, opBlez, opBgtz, opBltz, opJ, opJal};
    localparam logic [5:0] badOps [numIllegal] = '{6'b111111, 6'b010000, opSpecial};
    // legal, legal, bad opcode, bad funct
    localparam logic [5:0] sampleOps [numSample] = '{opSpecial, opLw, 6'b111111, opSpecial};
    localparam logic [5:0] sampleFns [numSample] = '{fnAdd, 6'd0, 6'd0, 6'b111111};
    // ctrlSignals field widths from the msb down
    localparam int fieldWidth [numFields] = '{3, 2, 1, 1, 1, aluFunWidth, 1, 1, 1, 2, 1, 1};

    string fieldName [numFields] = '{"pcSrc", "regDst", "regWr", "aluSrc1", "aluSrc2",
        "aluFun", "sign", "memWr", "memRd", "memToReg", "extOp", "luOp"};

    logic       clk;
    logic       rstN;
    instrWord   instruct;
    logic       irq;
    logic       pc31;
    ctrlSignals ctrl;
    ctrlSignals expected;
    logic       vecActive;
    int         seed = 32'h85c3;
    int         checkCount;
    int         errCount;
    int         testChecks;
    int         testErrs;

    controlUnit dut (
        .instruct (instruct),
        .irq      (irq),
        .pc31     (pc31),
        .ctrl     (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        #5;
        rstN = 1'b1;
    end

    // random word carrying op, and fn too for SPECIAL words
    function automatic instrWord makeWord(logic [5:0] op, logic [5:0] fn);
        instrWord w;
        w = $random(seed);
        w.r.opcode = op;
        if (op == opSpecial)
            w.r.funct = fn;
        return w;
    endfunction

    task automatic applyVec(instrWord w, logic irqIn, logic pc31In);
        @(posedge clk);
        #5;
        instruct  = w;
        irq       = irqIn;
        pc31      = pc31In;
        vecActive = 1'b1;
    endtask

    // waits for the last check of the test to land
    task automatic finishTest(string name);
        @(negedge clk);
        #1;
        vecActive = 1'b0;
        $display("test %-8s done: %0d vectors, %0d errors", name,
                 checkCount - testChecks, errCount - testErrs);
        testChecks = checkCount;
        testErrs   = errCount;
    endtask

    task automatic reportMismatch(ctrlSignals expv, ctrlSignals act);
        logic [31:0] diffBits;
        logic [31:0] expBits;
        logic [31:0] actBits;
        logic [31:0] mask;
        int          pos;
        logic        found;
        expBits  = 32'(expv);
        actBits  = 32'(act);
        diffBits = expBits ^ actBits;
        pos      = $bits(ctrlSignals);
        found    = 1'b0;
        for (int i = 0; i < numFields && !found; i++) begin
            pos  = pos - fieldWidth[i];
            mask = (32'd1 << fieldWidth[i]) - 32'd1;
            if (((diffBits >> pos) & mask) != 0) begin
                found = 1'b1;
                $display("[FAIL] t=%0t %s: expected %0h, actual %0h", $time, fieldName[i],
                         (expBits >> pos) & mask, (actBits >> pos) & mask);
            end
        end
        if (!found)
            $display("[FAIL] t=%0t ctrl: expected %h, actual %h", $time, expv, act);
    endtask

    // combinational outputs have settled by the falling edge
    always @(negedge clk) begin
        if (vecActive) begin
            expected   = expectCtrl(instruct, irq, pc31);
            checkCount = checkCount + 1;
            assert (ctrl === expected) else begin
                errCount = errCount + 1;
                reportMismatch(expected, ctrl);
            end
        end
    end

    initial begin
        int r;
        instruct   = '0;
        irq        = 1'b0;
        pc31       = 1'b0;
        vecActive  = 1'b0;
        checkCount = 0;
        errCount   = 0;
        testChecks = 0;
        testErrs   = 0;
        wait (rstN === 1'b1); // no stimulus while in reset
        for (int k = 0; k < numRtype; k++)
            applyVec(makeWord(opSpecial, functList[k]), 1'b0, 1'b0);
        finishTest("rtype");
        for (int k = 0; k < numItype; k++)
            applyVec(makeWord(opList[k], 6'd0), 1'b0, 1'b0);
        finishTest("itype");
        for (int k = 0; k < numIllegal; k++)
            applyVec(makeWord(badOps[k], 6'b111111), 1'b0, 1'b0); // exception row
        finishTest("illegal");
        for (int k = 0; k < numSample; k++)
            applyVec(makeWord(sampleOps[k], sampleFns[k]), 1'b1, 1'b0);
        finishTest("irq");
        for (int k = 0; k < numSample; k++)
            applyVec(makeWord(sampleOps[k], sampleFns[k]), 1'b1, 1'b1); // irq ignored
        finishTest("kernel");
        for (int k = 0; k < numRandom; k++) begin
            r = $random(seed);
            applyVec($random(seed), r[0], r[1]);
        end
        finishTest("random");
        $display("checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        #((totalVecs + 10) * 100);
        $display("timeout: the tests did not finish after %0d vectors", totalVecs);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== logic/controlUnit.sv ====
module controlUnit (
    input  isaPkg::instrWord    instruct,
    input  logic                irq,
    input  logic                pc31,
    output ctrlPkg::ctrlSignals ctrl
);
    import ctrlPkg::*;

    ctrlSignals decoded;
    logic       illegal;

    opcodeTable uOpcodeTable (
        .instruct (instruct),
        .decoded  (decoded),
        .illegal  (illegal)
    );

    trapControl uTrapControl (
        .decoded (decoded),
        .illegal (illegal),
        .irq     (irq),
        .pc31    (pc31),
        .ctrl    (ctrl)
    );

endmodule

// ==== logic/trapControl.sv ====
module trapControl (
    input  ctrlPkg::ctrlSignals decoded,
    input  logic                illegal,
    input  logic                irq,
    input  logic                pc31,
    output ctrlPkg::ctrlSignals ctrl
);
    import ctrlPkg::*;

    ctrlSignals trapRow;
    logic       userMode;
    logic       takeTrap;

    assign userMode = ~pc31;                        // kernel runs with pc[31] set
    assign takeTrap = userMode & (irq | illegal);

    // save pc+4 in xp and vector away, irq wins over the exception
    always_comb begin
        trapRow          = ctrlNop;
        trapRow.regWr    = 1'b1;
        trapRow.regDst   = dstXp;
        trapRow.memToReg = wbLink;
        trapRow.pcSrc    = irq ? pcIrq : pcExcept;
    end

    // kernel mode passes decoded through, nop for illegal words
    assign ctrl = takeTrap ? trapRow : decoded;

endmodule

// ==== logic/opcodeTable.sv ====
module opcodeTable (
    input  isaPkg::instrWord    instruct,
    output ctrlPkg::ctrlSignals decoded,
    output logic                illegal
);
    import isaPkg::*;
    import ctrlPkg::*;

    ctrlSignals functCtrl;
    logic       functIllegal;

    functTable uFunctTable (
        .instruct     (instruct),
        .functCtrl    (functCtrl),
        .functIllegal (functIllegal)
    );

    // rs op imm, result written to rt
    function automatic ctrlSignals immRow(
        logic [aluFunWidth-1:0] fun,
        logic                   sgn,
        logic                   ext
    );
        ctrlSignals row;
        row          = ctrlNop;
        row.pcSrc    = pcNext;
        row.regDst   = dstRt;
        row.regWr    = 1'b1;
        row.aluSrc2  = 1'b1;
        row.aluFun   = fun;
        row.sign     = sgn;
        row.extOp    = ext;
        row.memToReg = wbAlu;
        return row;
    endfunction

    // compare rs with rt or zero, offset always sign-extended
    function automatic ctrlSignals branchRow(logic [aluFunWidth-1:0] fun);
        ctrlSignals row;
        row        = ctrlNop;
        row.pcSrc  = pcBranch;
        row.aluFun = fun;
        row.extOp  = 1'b1;
        return row;
    endfunction

    always_comb begin
        decoded = ctrlNop;
        illegal = 1'b0;
        case (instruct.i.opcode)
            opSpecial: begin
                decoded = functCtrl;
                illegal = functIllegal;
            end
            opLw: begin
                decoded          = immRow(aluAdd, 1'b0, 1'b1); // base + offset
                decoded.memRd    = 1'b1;
                decoded.memToReg = wbMem;
            end
            opSw: begin
                decoded        = immRow(aluAdd, 1'b0, 1'b1);
                decoded.regWr  = 1'b0;
                decoded.regDst = dstRd;
                decoded.memWr  = 1'b1;
            end
            opLui: begin
                decoded      = immRow(aluAdd, 1'b0, 1'b1);
                decoded.luOp = 1'b1;
            end
            opAddi:  decoded = immRow(aluAdd, 1'b1, 1'b1);
            opAddiu: decoded = immRow(aluAdd, 1'b0, 1'b1);
            opAndi:  decoded = immRow(aluAnd, 1'b0, 1'b0); // zero-extended
            opSlti:  decoded = immRow(aluLt, 1'b1, 1'b1);
            opSltiu: decoded = immRow(aluLt, 1'b0, 1'b1);
            opBeq:   decoded = branchRow(aluEq);
            opBne:   decoded = branchRow(aluNeq);
            opBlez:  decoded = branchRow(aluLez);
            opBgtz:  decoded = branchRow(aluGtz);
            opBltz:  decoded = branchRow(aluLtz);
            opJ: begin
                decoded.pcSrc = pcJump;
            end
            opJal: begin
                decoded.pcSrc    = pcJump;
                decoded.regWr    = 1'b1;
                decoded.regDst   = dstRa;
                decoded.memToReg = wbLink; // return address
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

// ==== logic/functTable.sv ====
module functTable (
    input  isaPkg::instrWord    instruct,
    output ctrlPkg::ctrlSignals functCtrl,
    output logic                functIllegal
);
    import isaPkg::*;
    import ctrlPkg::*;

    // register-register ALU row, result written to rd
    function automatic ctrlSignals aluRow(
        logic [aluFunWidth-1:0] fun,
        logic                   sgn,
        logic                   shamtSel
    );
        ctrlSignals row;
        row          = ctrlNop;
        row.pcSrc    = pcNext;
        row.regDst   = dstRd;
        row.regWr    = 1'b1;
        row.aluSrc1  = shamtSel;
        row.aluFun   = fun;
        row.sign     = sgn;
        row.memToReg = wbAlu;
        return row;
    endfunction

    always_comb begin
        functCtrl    = ctrlNop;
        functIllegal = 1'b0;
        case (instruct.r.funct)
            fnAdd:  functCtrl = aluRow(aluAdd, 1'b1, 1'b0);
            fnAddu: functCtrl = aluRow(aluAdd, 1'b0, 1'b0);
            fnSub:  functCtrl = aluRow(aluSub, 1'b1, 1'b0);
            fnSubu: functCtrl = aluRow(aluSub, 1'b0, 1'b0);
            fnAnd:  functCtrl = aluRow(aluAnd, 1'b0, 1'b0);
            fnOr:   functCtrl = aluRow(aluOr, 1'b0, 1'b0);
            fnXor:  functCtrl = aluRow(aluXor, 1'b0, 1'b0);
            fnNor:  functCtrl = aluRow(aluNor, 1'b0, 1'b0);
            fnSll:  functCtrl = aluRow(aluSll, 1'b0, 1'b1); // shift by shamt
            fnSrl:  functCtrl = aluRow(aluSrl, 1'b0, 1'b1);
            fnSra:  functCtrl = aluRow(aluSra, 1'b0, 1'b1);
            fnSlt:  functCtrl = aluRow(aluLt, 1'b1, 1'b0);
            fnJr: begin
                functCtrl.pcSrc = pcReg; // jump to rs
            end
            fnJalr: begin
                functCtrl.pcSrc    = pcReg;
                functCtrl.regWr    = 1'b1;
                functCtrl.regDst   = dstRd;
                functCtrl.memToReg = wbLink; // link into rd
            end
            default: begin
                functIllegal = 1'b1; // row stays nop
            end
        endcase
    end

endmodule

// ==== logic/ctrlPkg.sv ====
package ctrlPkg;

    localparam int aluFunWidth = 6;

    typedef enum logic [2:0] {
        pcNext   = 3'd0, // pc+4
        pcBranch = 3'd1, // pc+4+offset when compare holds
        pcJump   = 3'd2, // target field
        pcReg    = 3'd3, // rs
        pcIrq    = 3'd4, // interrupt vector
        pcExcept = 3'd5  // exception vector
    } pcSrcT;

    typedef enum logic [1:0] {
        dstRd = 2'd0,
        dstRt = 2'd1,
        dstRa = 2'd2, // r31
        dstXp = 2'd3  // r26, holds the return pc on a trap
    } regDstT;

    typedef enum logic [1:0] {
        wbAlu  = 2'd0,
        wbMem  = 2'd1,
        wbLink = 2'd2 // pc+4
    } memToRegT;

    // arithmetic and logic
    localparam logic [aluFunWidth-1:0] aluAdd = 6'b000000;
    localparam logic [aluFunWidth-1:0] aluSub = 6'b000001;
    localparam logic [aluFunWidth-1:0] aluAnd = 6'b011000;
    localparam logic [aluFunWidth-1:0] aluOr  = 6'b011110;
    localparam logic [aluFunWidth-1:0] aluXor = 6'b010110;
    localparam logic [aluFunWidth-1:0] aluNor = 6'b010001;

    // shifts
    localparam logic [aluFunWidth-1:0] aluSll = 6'b100000;
    localparam logic [aluFunWidth-1:0] aluSrl = 6'b100001;
    localparam logic [aluFunWidth-1:0] aluSra = 6'b100011;

    // compares, also used by branches
    localparam logic [aluFunWidth-1:0] aluEq  = 6'b110011;
    localparam logic [aluFunWidth-1:0] aluNeq = 6'b110001;
    localparam logic [aluFunWidth-1:0] aluLt  = 6'b110101;
    localparam logic [aluFunWidth-1:0] aluLez = 6'b111101;
    localparam logic [aluFunWidth-1:0] aluLtz = 6'b111011;
    localparam logic [aluFunWidth-1:0] aluGtz = 6'b111111;

    typedef struct packed {
        pcSrcT                  pcSrc;
        regDstT                 regDst;
        logic                   regWr;
        logic                   aluSrc1;  // 1 selects shamt
        logic                   aluSrc2;  // 1 selects extended imm
        logic [aluFunWidth-1:0] aluFun;
        logic                   sign;
        logic                   memWr;
        logic                   memRd;
        memToRegT               memToReg;
        logic                   extOp;    // 1 sign-extends imm
        logic                   luOp;     // imm goes to upper half
    } ctrlSignals;

    // pc+4, nothing written
    localparam ctrlSignals ctrlNop = '0;

endpackage

// ==== logic/isaPkg.sv ====
package isaPkg;

    localparam int instrWidth  = 32;
    localparam int opcodeWidth = 6;
    localparam int regIdxWidth = 5;
    localparam int shamtWidth  = 5;
    localparam int functWidth  = 6;
    localparam int immWidth    = 16;
    localparam int targetWidth = instrWidth - opcodeWidth; // 26 bits

    // primary opcodes
    localparam logic [opcodeWidth-1:0] opSpecial = 6'b000000; // R-type, see funct
    localparam logic [opcodeWidth-1:0] opBltz    = 6'b000001;
    localparam logic [opcodeWidth-1:0] opJ       = 6'b000010;
    localparam logic [opcodeWidth-1:0] opJal     = 6'b000011;
    localparam logic [opcodeWidth-1:0] opBeq     = 6'b000100;
    localparam logic [opcodeWidth-1:0] opBne     = 6'b000101;
    localparam logic [opcodeWidth-1:0] opBlez    = 6'b000110;
    localparam logic [opcodeWidth-1:0] opBgtz    = 6'b000111;
    localparam logic [opcodeWidth-1:0] opAddi    = 6'b001000;
    localparam logic [opcodeWidth-1:0] opAddiu   = 6'b001001;
    localparam logic [opcodeWidth-1:0] opSlti    = 6'b001010;
    localparam logic [opcodeWidth-1:0] opSltiu   = 6'b001011;
    localparam logic [opcodeWidth-1:0] opAndi    = 6'b001100;
    localparam logic [opcodeWidth-1:0] opLui     = 6'b001111;
    localparam logic [opcodeWidth-1:0] opLw      = 6'b100011;
    localparam logic [opcodeWidth-1:0] opSw      = 6'b101011;

    // funct codes under opSpecial
    localparam logic [functWidth-1:0] fnSll  = 6'b000000;
    localparam logic [functWidth-1:0] fnSrl  = 6'b000010;
    localparam logic [functWidth-1:0] fnSra  = 6'b000011;
    localparam logic [functWidth-1:0] fnJr   = 6'b001000;
    localparam logic [functWidth-1:0] fnJalr = 6'b001001;
    localparam logic [functWidth-1:0] fnAdd  = 6'b100000;
    localparam logic [functWidth-1:0] fnAddu = 6'b100001;
    localparam logic [functWidth-1:0] fnSub  = 6'b100010;
    localparam logic [functWidth-1:0] fnSubu = 6'b100011;
    localparam logic [functWidth-1:0] fnAnd  = 6'b100100;
    localparam logic [functWidth-1:0] fnOr   = 6'b100101;
    localparam logic [functWidth-1:0] fnXor  = 6'b100110;
    localparam logic [functWidth-1:0] fnNor  = 6'b100111;
    localparam logic [functWidth-1:0] fnSlt  = 6'b101010;

    typedef struct packed {
        logic [opcodeWidth-1:0] opcode;
        logic [regIdxWidth-1:0] rs;
        logic [regIdxWidth-1:0] rt;
        logic [regIdxWidth-1:0] rd;
        logic [shamtWidth-1:0]  shamt;
        logic [functWidth-1:0]  funct;
    } rFormat;

    typedef struct packed {
        logic [opcodeWidth-1:0] opcode;
        logic [regIdxWidth-1:0] rs;
        logic [regIdxWidth-1:0] rt;
        logic [immWidth-1:0]    imm;
    } iFormat;

    typedef struct packed {
        logic [opcodeWidth-1:0] opcode;
        logic [targetWidth-1:0] target;
    } jFormat;

    // same 32 bits viewed as any of the three formats
    typedef union packed {
        rFormat r;
        iFormat i;
        jFormat j;
    } instrWord;

endpackage
